// File: include/osd_params.svh
// osd controller parameters
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

// --------------------
// identification
// --------------------
// byte returned by the version read
`define OSD_RTL_VERSION 8'h32

// --------------------
// memory write path
// --------------------
// write fifo holds 2**4 host words
`define OSD_FIFO_DEPTH_LOG2 4
// count lo, count hi, page lo, page hi
`define OSD_HDR_BYTES 4
// byte address step per 16-bit word
`define OSD_ADR_STEP 2

// default memory config
`define OSD_MEM_CFG_DEFAULT 6'b000101

`endif

// File: rtl/osd_cmd_decode.sv
// osd command decoder
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_cmd_decode
  import osd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      rx,
  input  logic      cmd,
  input  osd_byte_t wrdat,
  input  osd_byte_t osd_ctrl,
  output logic      reset_ctrl_wr,
  output logic      osd_ctrl_wr,
  output logic      chip_cfg_wr,
  output logic      cpu_cfg_wr,
  output logic      mem_cfg_wr,
  output logic      video_cfg_wr,
  output logic      floppy_cfg_wr,
  output logic      hdd_cfg_wr,
  output logic      joy_cfg_wr,
  output logic      mem_hdr_wr,
  output hdr_idx_t  mem_hdr_idx,
  output logic      mem_data_wr,
  output logic      cmd_start,
  output osd_byte_t rddat
);

  osd_cmd_e   cmd_code;
  logic [2:0] dat_cnt;
  logic       data_rx;
  logic       first_byte;
  logic       hdr_done;

  assign cmd_start  = rx && cmd;
  assign data_rx    = rx && !cmd;
  assign first_byte = (dat_cnt == 3'd0);
  // count saturates at the header length
  assign hdr_done   = (dat_cnt == 3'(`OSD_HDR_BYTES));

  // --------------------
  // command latch and byte counter
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_code <= CMD_NOP;
      dat_cnt  <= 3'd0;
    end else if (cmd_start) begin
      cmd_code <= osd_cmd_e'(wrdat[7:2]);
      dat_cnt  <= 3'd0;
    end else if (data_rx && !hdr_done) begin
      dat_cnt <= dat_cnt + 3'd1;
    end
  end

  // header byte index is the low count bits
  assign mem_hdr_idx = dat_cnt[1:0];

  // --------------------
  // per-function strobes
  // --------------------
  always_comb begin
    reset_ctrl_wr = 1'b0;
    osd_ctrl_wr   = 1'b0;
    chip_cfg_wr   = 1'b0;
    cpu_cfg_wr    = 1'b0;
    mem_cfg_wr    = 1'b0;
    video_cfg_wr  = 1'b0;
    floppy_cfg_wr = 1'b0;
    hdd_cfg_wr    = 1'b0;
    joy_cfg_wr    = 1'b0;
    mem_hdr_wr    = 1'b0;
    mem_data_wr   = 1'b0;
    if (data_rx) begin
      case (cmd_code)
        CMD_RESET_CTRL:   reset_ctrl_wr = first_byte;
        CMD_OSD_CTRL:     osd_ctrl_wr   = first_byte;
        CMD_CHIP_CFG:     chip_cfg_wr   = first_byte;
        CMD_CPU_CFG:      cpu_cfg_wr    = first_byte;
        CMD_MEMORY_CFG:   mem_cfg_wr    = first_byte;
        CMD_VIDEO_CFG:    video_cfg_wr  = first_byte;
        CMD_FLOPPY_CFG:   floppy_cfg_wr = first_byte;
        CMD_HARDDISK_CFG: hdd_cfg_wr    = first_byte;
        CMD_JOYSTICK_CFG: joy_cfg_wr    = first_byte;
        CMD_MEM_WRITE: begin
          // header bytes first, then payload
          mem_hdr_wr  = !hdr_done;
          mem_data_wr = hdr_done;
        end
        // clock control carries no register
        CMD_CLOCK_CTRL: begin
        end
        default: begin
        end
      endcase
    end
  end

  // read byte back to the shifter
  assign rddat = (cmd_code == CMD_VERSION) ? `OSD_RTL_VERSION : osd_ctrl;

endmodule

// File: rtl/osd_config_regs.sv
// osd configuration registers
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_config_regs
  import osd_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        reset_ctrl_wr,
  input  logic        osd_ctrl_wr,
  input  logic        chip_cfg_wr,
  input  logic        cpu_cfg_wr,
  input  logic        mem_cfg_wr,
  input  logic        video_cfg_wr,
  input  logic        floppy_cfg_wr,
  input  logic        hdd_cfg_wr,
  input  logic        joy_cfg_wr,
  input  osd_byte_t   wrdat,
  output logic        osd_enable,
  output logic        key_disable,
  output logic        usrrst,
  output logic        cpurst,
  output logic        cpuhlt,
  output chip_cfg_t   chipset_config,
  output cpu_cfg_t    cpu_config,
  output mem_cfg_t    memory_config,
  output ide_cfg_t    ide_config,
  output floppy_cfg_t floppy_config,
  output filter_t     lr_filter,
  output filter_t     hr_filter,
  output scanline_t   scanline,
  output autofire_t   autofire_config
);

  // chipset bits 3:2 and 0 take effect at once
  logic [1:0] chip_hi;
  logic       chip_lo;
  logic       chip_live1;

  // staged values, power-up defaults
  mem_cfg_t mem_stage   = `OSD_MEM_CFG_DEFAULT;
  cpu_cfg_t cpu_stage   = '0;
  ide_cfg_t ide_stage   = '0;
  logic     chip1_stage = 1'b0;

  // --------------------
  // immediate fields
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_enable      <= 1'b0;
      key_disable     <= 1'b0;
      usrrst          <= 1'b0;
      // cpu held in reset and halt until the host releases it
      cpurst          <= 1'b1;
      cpuhlt          <= 1'b1;
      chip_hi         <= 2'b00;
      chip_lo         <= 1'b0;
      floppy_config   <= '0;
      lr_filter       <= '0;
      hr_filter       <= '0;
      scanline        <= '0;
      autofire_config <= '0;
    end else begin
      if (reset_ctrl_wr)
        {cpuhlt, cpurst, usrrst} <= wrdat[2:0];
      if (osd_ctrl_wr)
        {key_disable, osd_enable} <= wrdat[1:0];
      if (chip_cfg_wr) begin
        chip_hi <= wrdat[3:2];
        chip_lo <= wrdat[0];
      end
      // hires, lores, scanline from msb down
      if (video_cfg_wr)
        {hr_filter, lr_filter, scanline} <= wrdat[5:0];
      if (floppy_cfg_wr)
        floppy_config <= wrdat[3:0];
      if (joy_cfg_wr)
        autofire_config <= wrdat[1:0];
    end
  end

  // --------------------
  // staged fields
  // --------------------
  always_ff @(posedge clk) begin
    if (mem_cfg_wr)
      mem_stage <= wrdat[5:0];
    if (cpu_cfg_wr)
      cpu_stage <= wrdat[3:0];
    if (hdd_cfg_wr)
      ide_stage <= wrdat[2:0];
    if (chip_cfg_wr)
      chip1_stage <= wrdat[1];
  end

  // staged values go live only while reset is high
  always_ff @(posedge clk) begin
    if (reset) begin
      memory_config <= mem_stage;
      cpu_config    <= cpu_stage;
      ide_config    <= ide_stage;
      chip_live1    <= chip1_stage;
    end
  end

  assign chipset_config = {chip_hi, chip_live1, chip_lo};

endmodule

// File: rtl/osd_ctrl_top.sv
// osd control core top
`timescale 1ns/1ps

module osd_ctrl_top
  import osd_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  // spi byte side
  input  logic        rx,
  input  logic        cmd,
  input  osd_byte_t   wrdat,
  output osd_byte_t   rddat,
  input  osd_byte_t   osd_ctrl,
  // configuration and control
  output logic        osd_enable,
  output logic        key_disable,
  output logic        usrrst,
  output logic        cpurst,
  output logic        cpuhlt,
  output chip_cfg_t   chipset_config,
  output cpu_cfg_t    cpu_config,
  output mem_cfg_t    memory_config,
  output ide_cfg_t    ide_config,
  output floppy_cfg_t floppy_config,
  output filter_t     lr_filter,
  output filter_t     hr_filter,
  output scanline_t   scanline,
  output autofire_t   autofire_config,
  // host bus
  output logic        host_cs,
  output logic        host_we,
  output logic [1:0]  host_bs,
  output host_adr_t   host_adr,
  output host_word_t  host_wdat,
  input  logic        host_ack,
  output logic        fifo_full
);

  // decoder strobes
  logic     reset_ctrl_wr;
  logic     osd_ctrl_wr;
  logic     chip_cfg_wr;
  logic     cpu_cfg_wr;
  logic     mem_cfg_wr;
  logic     video_cfg_wr;
  logic     floppy_cfg_wr;
  logic     hdd_cfg_wr;
  logic     joy_cfg_wr;
  // memory write path
  logic     mem_hdr_wr;
  hdr_idx_t mem_hdr_idx;
  logic     mem_data_wr;
  logic     cmd_start;

  osd_cmd_decode osd_cmd_decode_inst (
    .clk           (clk),
    .reset         (reset),
    .rx            (rx),
    .cmd           (cmd),
    .wrdat         (wrdat),
    .osd_ctrl      (osd_ctrl),
    .reset_ctrl_wr (reset_ctrl_wr),
    .osd_ctrl_wr   (osd_ctrl_wr),
    .chip_cfg_wr   (chip_cfg_wr),
    .cpu_cfg_wr    (cpu_cfg_wr),
    .mem_cfg_wr    (mem_cfg_wr),
    .video_cfg_wr  (video_cfg_wr),
    .floppy_cfg_wr (floppy_cfg_wr),
    .hdd_cfg_wr    (hdd_cfg_wr),
    .joy_cfg_wr    (joy_cfg_wr),
    .mem_hdr_wr    (mem_hdr_wr),
    .mem_hdr_idx   (mem_hdr_idx),
    .mem_data_wr   (mem_data_wr),
    .cmd_start     (cmd_start),
    .rddat         (rddat)
  );

  osd_config_regs osd_config_regs_inst (
    .clk             (clk),
    .reset           (reset),
    .reset_ctrl_wr   (reset_ctrl_wr),
    .osd_ctrl_wr     (osd_ctrl_wr),
    .chip_cfg_wr     (chip_cfg_wr),
    .cpu_cfg_wr      (cpu_cfg_wr),
    .mem_cfg_wr      (mem_cfg_wr),
    .video_cfg_wr    (video_cfg_wr),
    .floppy_cfg_wr   (floppy_cfg_wr),
    .hdd_cfg_wr      (hdd_cfg_wr),
    .joy_cfg_wr      (joy_cfg_wr),
    .wrdat           (wrdat),
    .osd_enable      (osd_enable),
    .key_disable     (key_disable),
    .usrrst          (usrrst),
    .cpurst          (cpurst),
    .cpuhlt          (cpuhlt),
    .chipset_config  (chipset_config),
    .cpu_config      (cpu_config),
    .memory_config   (memory_config),
    .ide_config      (ide_config),
    .floppy_config   (floppy_config),
    .lr_filter       (lr_filter),
    .hr_filter       (hr_filter),
    .scanline        (scanline),
    .autofire_config (autofire_config)
  );

  osd_mem_writer osd_mem_writer_inst (
    .clk         (clk),
    .reset       (reset),
    .cmd_start   (cmd_start),
    .mem_hdr_wr  (mem_hdr_wr),
    .mem_hdr_idx (mem_hdr_idx),
    .mem_data_wr (mem_data_wr),
    .wrdat       (wrdat),
    .host_ack    (host_ack),
    .host_cs     (host_cs),
    .host_we     (host_we),
    .host_bs     (host_bs),
    .host_adr    (host_adr),
    .host_wdat   (host_wdat),
    .fifo_full   (fifo_full)
  );

endmodule

// File: rtl/osd_mem_writer.sv
// system memory writer
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_mem_writer
  import osd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_start,
  input  logic       mem_hdr_wr,
  input  hdr_idx_t   mem_hdr_idx,
  input  logic       mem_data_wr,
  input  osd_byte_t  wrdat,
  input  logic       host_ack,
  output logic       host_cs,
  output logic       host_we,
  output logic [1:0] host_bs,
  output host_adr_t  host_adr,
  output host_word_t host_wdat,
  output logic       fifo_full
);

  // address halves
  mem_half_t  mem_cnt;
  mem_half_t  mem_page;
  // byte pairing
  logic       mem_toggle;
  osd_byte_t  hi_byte;
  // write machine
  wr_state_e  wr_state;
  logic       pop_pending;
  logic       fifo_push;
  logic       fifo_empty;
  logic [31:0] mem_adr;

  // --------------------
  // byte pairing
  // --------------------
  // second byte of a pair completes the word
  assign fifo_push = mem_data_wr && mem_toggle;

  always_ff @(posedge clk) begin
    if (reset || cmd_start)
      mem_toggle <= 1'b0;
    else if (mem_data_wr)
      mem_toggle <= !mem_toggle;
  end

  // first byte is the high half
  always_ff @(posedge clk) begin
    if (mem_data_wr && !mem_toggle)
      hi_byte <= wrdat;
  end

  osd_write_fifo #(
    .DEPTH_LOG2 (`OSD_FIFO_DEPTH_LOG2)
  ) osd_write_fifo_inst (
    .clk   (clk),
    .reset (reset),
    .wr_en (fifo_push),
    .din   ({hi_byte, wrdat}),
    .rd_en (pop_pending),
    .dout  (host_wdat),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  // --------------------
  // header and address
  // --------------------
  always_ff @(posedge clk) begin
    if (mem_hdr_wr) begin
      case (mem_hdr_idx)
        2'd0: mem_cnt[7:0]   <= wrdat;
        2'd1: mem_cnt[15:8]  <= wrdat;
        2'd2: mem_page[7:0]  <= wrdat;
        2'd3: mem_page[15:8] <= wrdat;
        default: begin
        end
      endcase
    end else if (pop_pending) begin
      // one word done, step to next
      mem_cnt <= mem_cnt + 16'(`OSD_ADR_STEP);
    end
  end

  assign mem_adr  = {mem_page, mem_cnt};
  assign host_adr = mem_adr[23:0];

  // --------------------
  // host write machine
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state    <= WR_IDLE;
      host_cs     <= 1'b0;
      host_we     <= 1'b0;
      host_bs     <= 2'b00;
      pop_pending <= 1'b0;
    end else begin
      // acked word leaves the fifo on the next edge
      pop_pending <= (wr_state == WR_WRITE) && host_ack;
      if (cmd_start) begin
        // new command aborts, fifo contents kept
        wr_state <= WR_IDLE;
        host_cs  <= 1'b0;
        host_we  <= 1'b0;
        host_bs  <= 2'b00;
      end else begin
        case (wr_state)
          WR_IDLE: begin
            // wait until the previous pop has landed
            if (!fifo_empty && !pop_pending) begin
              wr_state <= WR_WRITE;
              host_cs  <= 1'b1;
              host_we  <= 1'b1;
              host_bs  <= 2'b11;
            end
          end
          WR_WRITE: begin
            if (host_ack) begin
              wr_state <= WR_IDLE;
              host_cs  <= 1'b0;
              host_we  <= 1'b0;
              host_bs  <= 2'b00;
            end
          end
          default: wr_state <= WR_IDLE;
        endcase
      end
    end
  end

endmodule

// File: rtl/osd_pkg.sv
// osd controller types
package osd_pkg;

  // spi and host bus data
  typedef logic [7:0]  osd_byte_t;
  typedef logic [15:0] host_word_t;
  typedef logic [23:0] host_adr_t;
  // one half of the 32-bit memory address
  typedef logic [15:0] mem_half_t;
  typedef logic [1:0]  hdr_idx_t;

  // configuration fields
  typedef logic [5:0] mem_cfg_t;
  typedef logic [3:0] cpu_cfg_t;
  typedef logic [3:0] chip_cfg_t;
  typedef logic [2:0] ide_cfg_t;
  typedef logic [3:0] floppy_cfg_t;
  typedef logic [1:0] filter_t;
  typedef logic [1:0] scanline_t;
  typedef logic [1:0] autofire_t;

  // command codes, wrdat[7:2] of the command byte
  typedef enum logic [5:0] {
    CMD_NOP          = 6'b000000,
    CMD_RESET_CTRL   = 6'b000010,
    CMD_CLOCK_CTRL   = 6'b001010,
    CMD_OSD_CTRL     = 6'b010010,
    CMD_CHIP_CFG     = 6'b000001,
    CMD_CPU_CFG      = 6'b001001,
    CMD_MEMORY_CFG   = 6'b010001,
    CMD_VIDEO_CFG    = 6'b011001,
    CMD_FLOPPY_CFG   = 6'b100001,
    CMD_HARDDISK_CFG = 6'b101001,
    CMD_JOYSTICK_CFG = 6'b110001,
    CMD_MEM_WRITE    = 6'b001011,
    CMD_VERSION      = 6'b100010
  } osd_cmd_e;

  // host write machine
  typedef enum logic {
    WR_IDLE  = 1'b0,
    WR_WRITE = 1'b1
  } wr_state_e;

endpackage

// File: rtl/osd_write_fifo.sv
// synchronous word fifo
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_write_fifo
  import osd_pkg::*;
#(
  parameter int DEPTH_LOG2 = `OSD_FIFO_DEPTH_LOG2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       wr_en,
  input  host_word_t din,
  input  logic       rd_en,
  output host_word_t dout,
  output logic       full,
  output logic       empty
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  host_word_t              mem [DEPTH];
  logic [DEPTH_LOG2-1:0]   wr_ptr;
  logic [DEPTH_LOG2-1:0]   rd_ptr;
  // one extra bit so a full buffer is distinct from empty
  logic [DEPTH_LOG2:0]     count;
  logic                    push;
  logic                    pop;

  // push while full is dropped
  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  // storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // head word
  assign dout  = mem[rd_ptr];
  assign full  = (count == (DEPTH_LOG2+1)'(DEPTH));
  assign empty = (count == '0);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the osd control core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=osd_ctrl_sim

verilator --binary --assert -Wno-fatal --top-module osd_ctrl_tb \
  -f vlog.f -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0

// File: verif/osd_ctrl_properties.sv
// host bus and fifo assertions
`timescale 1ns/1ps

module osd_ctrl_properties (
  input logic       clk,
  input logic       reset,
  input logic       cmd_start,
  input logic       host_cs,
  input logic       host_ack,
  input logic [1:0] host_bs,
  input logic       empty
);

  // --------------------
  // host bus
  // --------------------
  // request held until the host answers, unless a new command aborts it
  property cs_held_until_ack;
    @(posedge clk) disable iff (reset)
      host_cs && !host_ack && !cmd_start |=> host_cs;
  endproperty

  // full word writes only
  property bs_full_word;
    @(posedge clk) disable iff (reset)
      host_cs |-> (host_bs == 2'b11);
  endproperty

  // --------------------
  // fifo flags
  // --------------------
  // a host write starts only with a word in the fifo
  property write_needs_word;
    @(posedge clk) disable iff (reset)
      $rose(host_cs) |-> !$past(empty);
  endproperty

  cs_held_until_ack_a: assert property (cs_held_until_ack)
    else $error("host_cs dropped before host_ack");
  bs_full_word_a: assert property (bs_full_word)
    else $error("host_bs not 11 during a host write");
  write_needs_word_a: assert property (write_needs_word)
    else $error("host write started with the fifo empty");

endmodule

bind osd_mem_writer osd_ctrl_properties osd_ctrl_properties_inst (
  .clk       (clk),
  .reset     (reset),
  .cmd_start (cmd_start),
  .host_cs   (host_cs),
  .host_ack  (host_ack),
  .host_bs   (host_bs),
  .empty     (fifo_empty)
);

// File: verif/osd_ctrl_tb.sv
// osd control core testbench
`timescale 1ns/1ps

module osd_ctrl_tb
  import osd_pkg::*;
();

  // test sizes
  localparam int N_IMM    = 24;
  localparam int N_NOP    = 8;
  localparam int N_RST    = 4;
  localparam int N_STG    = 3;
  localparam int N_RD     = 16;
  localparam int N_MEM    = 6;
  // worst case cycles per spi byte and per host word
  localparam int BYTE_CYC = 6;
  localparam int WORD_CYC = 8;
  localparam int WORST_CYC = 5 + N_IMM * (4 * BYTE_CYC + 2) + N_NOP * (3 * BYTE_CYC + 1)
                           + N_RST * (N_STG * (4 * BYTE_CYC + 2) + 4) + N_RD * (BYTE_CYC + 1)
                           + N_MEM * (17 * BYTE_CYC + 6 * WORD_CYC + 4);
  localparam int CYCLE_LIMIT = 2 * WORST_CYC;
  // version byte returned under the version command
  localparam logic [7:0] VERSION_BYTE = 8'h32;

  logic        clk = 1'b0;
  logic        reset;
  logic        rx;
  logic        cmd;
  osd_byte_t   wrdat;
  osd_byte_t   osd_ctrl;
  osd_byte_t   rddat;
  logic        osd_enable;
  logic        key_disable;
  logic        usrrst;
  logic        cpurst;
  logic        cpuhlt;
  chip_cfg_t   chipset_config;
  cpu_cfg_t    cpu_config;
  mem_cfg_t    memory_config;
  ide_cfg_t    ide_config;
  floppy_cfg_t floppy_config;
  filter_t     lr_filter;
  filter_t     hr_filter;
  scanline_t   scanline;
  autofire_t   autofire_config;
  logic        host_cs;
  logic        host_we;
  logic [1:0]  host_bs;
  host_adr_t   host_adr;
  host_word_t  host_wdat;
  logic        host_ack = 1'b0;
  logic        fifo_full;

  // --------------------
  // reference model state
  // --------------------
  logic        exp_osd_enable;
  logic        exp_key_disable;
  logic        exp_usrrst;
  logic        exp_cpurst;
  logic        exp_cpuhlt;
  logic [1:0]  exp_chip_hi;
  logic        exp_chip_lo;
  logic        exp_chip_live1;
  floppy_cfg_t exp_floppy;
  filter_t     exp_lr;
  filter_t     exp_hr;
  scanline_t   exp_scan;
  autofire_t   exp_autofire;
  mem_cfg_t    exp_mem;
  cpu_cfg_t    exp_cpu;
  ide_cfg_t    exp_ide;
  // staged copies, power-up values
  mem_cfg_t    stg_mem = 6'b000101;
  cpu_cfg_t    stg_cpu = '0;
  ide_cfg_t    stg_ide = '0;
  logic        stg_chip1 = 1'b0;
  // expected host writes, address then data
  logic [39:0] exp_writes[$];

  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  int    ack_wait = 0;
  string cur_test = "reset";

  always #2 clk = ~clk;

  osd_ctrl_top osd_ctrl_top_inst (
    .clk             (clk),
    .reset           (reset),
    .rx              (rx),
    .cmd             (cmd),
    .wrdat           (wrdat),
    .rddat           (rddat),
    .osd_ctrl        (osd_ctrl),
    .osd_enable      (osd_enable),
    .key_disable     (key_disable),
    .usrrst          (usrrst),
    .cpurst          (cpurst),
    .cpuhlt          (cpuhlt),
    .chipset_config  (chipset_config),
    .cpu_config      (cpu_config),
    .memory_config   (memory_config),
    .ide_config      (ide_config),
    .floppy_config   (floppy_config),
    .lr_filter       (lr_filter),
    .hr_filter       (hr_filter),
    .scanline        (scanline),
    .autofire_config (autofire_config),
    .host_cs         (host_cs),
    .host_we         (host_we),
    .host_bs         (host_bs),
    .host_adr        (host_adr),
    .host_wdat       (host_wdat),
    .host_ack        (host_ack),
    .fifo_full       (fifo_full)
  );

  // --------------------
  // check helpers
  // --------------------
  task automatic compare_field(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Mismatch %s %s: expected %0h actual %0h", cur_test, field, expected, actual);
    end
  endtask

  task automatic check_regs();
    compare_field("osd_enable", 32'(exp_osd_enable), 32'(osd_enable));
    compare_field("key_disable", 32'(exp_key_disable), 32'(key_disable));
    compare_field("usrrst", 32'(exp_usrrst), 32'(usrrst));
    compare_field("cpurst", 32'(exp_cpurst), 32'(cpurst));
    compare_field("cpuhlt", 32'(exp_cpuhlt), 32'(cpuhlt));
    compare_field("chipset_config", 32'({exp_chip_hi, exp_chip_live1, exp_chip_lo}),
                  32'(chipset_config));
    compare_field("cpu_config", 32'(exp_cpu), 32'(cpu_config));
    compare_field("memory_config", 32'(exp_mem), 32'(memory_config));
    compare_field("ide_config", 32'(exp_ide), 32'(ide_config));
    compare_field("floppy_config", 32'(exp_floppy), 32'(floppy_config));
    compare_field("lr_filter", 32'(exp_lr), 32'(lr_filter));
    compare_field("hr_filter", 32'(exp_hr), 32'(hr_filter));
    compare_field("scanline", 32'(exp_scan), 32'(scanline));
    compare_field("autofire_config", 32'(exp_autofire), 32'(autofire_config));
  endtask

  // --------------------
  // model updates
  // --------------------
  // immediate fields to defaults, staged copies go live
  task automatic model_reset();
    exp_osd_enable  = 1'b0;
    exp_key_disable = 1'b0;
    exp_usrrst      = 1'b0;
    exp_cpurst      = 1'b1;
    exp_cpuhlt      = 1'b1;
    exp_chip_hi     = 2'b00;
    exp_chip_lo     = 1'b0;
    exp_floppy      = '0;
    exp_lr          = '0;
    exp_hr          = '0;
    exp_scan        = '0;
    exp_autofire    = '0;
    exp_mem         = stg_mem;
    exp_cpu         = stg_cpu;
    exp_ide         = stg_ide;
    exp_chip_live1  = stg_chip1;
  endtask

  // first data byte under a config command
  task automatic apply_write(input logic [5:0] code, input logic [7:0] d);
    case (code)
      CMD_RESET_CTRL: begin
        exp_cpuhlt = d[2];
        exp_cpurst = d[1];
        exp_usrrst = d[0];
      end
      CMD_OSD_CTRL: begin
        exp_key_disable = d[1];
        exp_osd_enable  = d[0];
      end
      CMD_CHIP_CFG: begin
        exp_chip_hi = d[3:2];
        exp_chip_lo = d[0];
        stg_chip1   = d[1];
      end
      CMD_VIDEO_CFG: begin
        exp_hr   = d[5:4];
        exp_lr   = d[3:2];
        exp_scan = d[1:0];
      end
      CMD_FLOPPY_CFG:   exp_floppy   = d[3:0];
      CMD_JOYSTICK_CFG: exp_autofire = d[1:0];
      CMD_MEMORY_CFG:   stg_mem      = d[5:0];
      CMD_CPU_CFG:      stg_cpu      = d[3:0];
      CMD_HARDDISK_CFG: stg_ide      = d[2:0];
      default: begin
      end
    endcase
  endtask

  function automatic bit is_known_code(input logic [5:0] code);
    case (code)
      CMD_RESET_CTRL, CMD_CLOCK_CTRL, CMD_OSD_CTRL, CMD_CHIP_CFG, CMD_CPU_CFG,
      CMD_MEMORY_CFG, CMD_VIDEO_CFG, CMD_FLOPPY_CFG, CMD_HARDDISK_CFG,
      CMD_JOYSTICK_CFG, CMD_MEM_WRITE, CMD_VERSION: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // --------------------
  // stimulus
  // --------------------
  // idle gap, then a one-cycle rx pulse
  task automatic send_byte(input logic is_cmd, input logic [7:0] d);
    int gap;
    gap = $urandom_range(1, 4);
    repeat (gap) @(posedge clk);
    rx    <= 1'b1;
    cmd   <= is_cmd;
    wrdat <= d;
    @(posedge clk);
    rx  <= 1'b0;
    cmd <= 1'b0;
  endtask

  task automatic send_command(input logic [5:0] code);
    send_byte(1'b1, {code, 2'($urandom)});
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    model_reset();
  endtask

  task automatic wait_host_drain();
    while (exp_writes.size() != 0 || host_cs)
      @(posedge clk);
    // let the last pop land
    repeat (3) @(posedge clk);
  endtask

  // --------------------
  // host responder
  // --------------------
  task automatic record_host_write();
    logic [39:0] expected;
    if (exp_writes.size() == 0) begin
      errors++;
      $display("Error in %s: host write to %0h with no expected word", cur_test, host_adr);
    end else begin
      expected = exp_writes.pop_front();
      compare_field("host_adr", 32'(expected[39:16]), 32'(host_adr));
      compare_field("host_wdat", 32'(expected[15:0]), 32'(host_wdat));
      compare_field("host_we", 32'(1), 32'(host_we));
      compare_field("host_bs", 32'(2'b11), 32'(host_bs));
    end
  endtask

  // one-cycle ack after a random 0..3 cycle wait
  always @(posedge clk) begin
    if (reset) begin
      host_ack <= 1'b0;
      ack_wait <= $urandom_range(0, 3);
    end else begin
      if (host_cs && host_ack)
        record_host_write();
      if (host_ack) begin
        host_ack <= 1'b0;
      end else if (host_cs) begin
        if (ack_wait == 0) begin
          host_ack <= 1'b1;
          ack_wait <= $urandom_range(0, 3);
        end else begin
          ack_wait <= ack_wait - 1;
        end
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles during test %s", CYCLE_LIMIT, cur_test);
      $display("checks %0d errors %0d", checks, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    logic [5:0] code;
    logic [7:0] d;
    logic [7:0] hi;
    mem_half_t  cnt;
    mem_half_t  page;
    mem_half_t  word_cnt;
    int         k;
    int         nbytes;
    void'($urandom(32'hf0aa32b5));
    reset    = 1'b1;
    rx       = 1'b0;
    cmd      = 1'b0;
    wrdat    = '0;
    osd_ctrl = '0;
    model_reset();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_regs();
    compare_field("host_cs", 32'(0), 32'(host_cs));
    compare_field("host_we", 32'(0), 32'(host_we));
    compare_field("host_bs", 32'(0), 32'(host_bs));
    compare_field("fifo_full", 32'(0), 32'(fifo_full));

    // immediate writes, extra bytes ignored
    cur_test = "immediate";
    for (int n = 0; n < N_IMM; n++) begin
      k = $urandom_range(0, 5);
      case (k)
        0: code = CMD_OSD_CTRL;
        1: code = CMD_VIDEO_CFG;
        2: code = CMD_FLOPPY_CFG;
        3: code = CMD_JOYSTICK_CFG;
        4: code = CMD_RESET_CTRL;
        default: code = CMD_CHIP_CFG;
      endcase
      d = 8'($urandom);
      send_command(code);
      send_byte(1'b0, d);
      apply_write(code, d);
      @(negedge clk);
      check_regs();
      repeat ($urandom_range(0, 2)) send_byte(1'b0, 8'($urandom));
      @(negedge clk);
      check_regs();
    end

    // clock control and unknown codes are no-ops
    cur_test = "no_op";
    for (int n = 0; n < N_NOP; n++) begin
      if ($urandom_range(0, 1) == 0) begin
        code = CMD_CLOCK_CTRL;
      end else begin
        code = 6'($urandom);
        while (is_known_code(code))
          code = 6'($urandom);
      end
      send_command(code);
      repeat ($urandom_range(1, 2)) send_byte(1'b0, 8'($urandom));
      @(negedge clk);
      check_regs();
    end

    // staged writes show only after reset
    cur_test = "staged";
    for (int r = 0; r < N_RST; r++) begin
      for (int n = 0; n < N_STG; n++) begin
        k = $urandom_range(0, 3);
        case (k)
          0: code = CMD_MEMORY_CFG;
          1: code = CMD_CPU_CFG;
          2: code = CMD_HARDDISK_CFG;
          default: code = CMD_CHIP_CFG;
        endcase
        d = 8'($urandom);
        send_command(code);
        send_byte(1'b0, d);
        apply_write(code, d);
        @(negedge clk);
        check_regs();
        // later bytes must not restage
        repeat ($urandom_range(0, 2)) send_byte(1'b0, 8'($urandom));
        @(negedge clk);
        check_regs();
      end
      pulse_reset();
      @(negedge clk);
      check_regs();
    end

    // read byte under the latched command
    cur_test = "read_byte";
    for (int n = 0; n < N_RD; n++) begin
      code = ($urandom_range(0, 2) == 0) ? CMD_VERSION : 6'($urandom);
      @(posedge clk);
      osd_ctrl <= 8'($urandom);
      send_command(code);
      @(negedge clk);
      compare_field("rddat", 32'((code == CMD_VERSION) ? VERSION_BYTE : osd_ctrl),
                    32'(rddat));
    end

    // system memory writes over the host bus
    cur_test = "mem_write";
    for (int n = 0; n < N_MEM; n++) begin
      cnt    = 16'($urandom);
      page   = 16'($urandom);
      nbytes = $urandom_range(2, 12);
      hi     = '0;
      send_command(CMD_MEM_WRITE);
      send_byte(1'b0, cnt[7:0]);
      send_byte(1'b0, cnt[15:8]);
      send_byte(1'b0, page[7:0]);
      send_byte(1'b0, page[15:8]);
      for (int i = 0; i < nbytes; i++) begin
        d = 8'($urandom);
        if (i % 2 == 0) begin
          hi = d;
        end else begin
          // two bytes per word, count half steps by 2
          word_cnt = cnt + 16'(2 * (i / 2));
          exp_writes.push_back({page[7:0], word_cnt, hi, d});
        end
        send_byte(1'b0, d);
      end
      wait_host_drain();
      @(negedge clk);
      compare_field("fifo_full", 32'(0), 32'(fifo_full));
      check_regs();
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
rtl/osd_pkg.sv
rtl/osd_write_fifo.sv
rtl/osd_cmd_decode.sv
rtl/osd_config_regs.sv
rtl/osd_mem_writer.sv
rtl/osd_ctrl_top.sv
verif/osd_ctrl_properties.sv
verif/osd_ctrl_tb.sv
